//--- Bender.yml
package:
  name: mem_mux

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/mem_mux_pkg.sv
      - logic/mem_mux_dynamic.sv
      - logic/mem_bank.sv
      - logic/mem_mux_subsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/mem_mux_sva.sv
      - test/mem_mux_tb.sv

//--- compile.f
+incdir+include
logic/mem_mux_pkg.sv
logic/mem_mux_dynamic.sv
logic/mem_bank.sv
logic/mem_mux_subsys.sv
test/mem_mux_sva.sv
test/mem_mux_tb.sv

//--- include/mem_mux_config.svh
//####################################################################
// Build-time sizes for the channel multiplexer and its banks.
// MEM_NB_OUT_CHAN must divide MEM_NB_IN_CHAN evenly.
// MEM_DW must be a multiple of 8 since byte enables cover whole bytes.
//####################################################################

`ifndef MEM_MUX_CONFIG_SVH
`define MEM_MUX_CONFIG_SVH

// initiator channels seen by the multiplexer.
`define MEM_NB_IN_CHAN 4

// bank ports, one single-port bank behind each.
`define MEM_NB_OUT_CHAN 2

// word address width inside one bank, so a bank holds 2**MEM_AW words.
`define MEM_AW 6

`define MEM_DW 32  // data width in bits.

// transaction id width.
// The id is echoed back unchanged in every response.
`define MEM_IW 4

`endif

//--- logic/mem_bank.sv
//####################################################################
// Single-port word memory with byte enables.
// Grants every request unless stall is high. Answers one cycle later.
// Content is not initialised, so reads of unwritten words give X.
//####################################################################

`timescale 1ns/1ns

`include "mem_mux_config.svh"

module mem_bank (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  stall,

  input  logic                  req,
  input  mem_mux_pkg::mem_req_t req_data,
  output logic                  gnt,

  output logic                  r_valid,
  output mem_mux_pkg::mem_rsp_t rsp
);

  localparam int unsigned DEPTH = 2 ** `MEM_AW;
  localparam int unsigned NBE   = `MEM_DW / 8;

  logic [`MEM_DW-1:0] mem [DEPTH];

  // the bank is free in every cycle it is not stalled.
  assign gnt = req & ~stall;

  //####################################################################
  // storage
  //####################################################################

  always_ff @(posedge clk_i) begin : mem_write
    if (gnt && !req_data.wen) begin
      for (int unsigned b = 0; b < NBE; b++) begin
        if (req_data.be[b]) begin
          mem[req_data.addr][8*b +: 8] <= req_data.data[8*b +: 8];
        end
      end
    end
  end

  //####################################################################
  // response
  //####################################################################

  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= gnt;  // one response per grant.
    end
  end

  // Payload is only meaningful with r_valid.
  always_ff @(posedge clk_i) begin : rsp_reg
    if (gnt) begin
      rsp.data <= req_data.wen ? mem[req_data.addr] : '0;
      rsp.id   <= req_data.id;
      rsp.opc  <= 1'b0;   // no error sources in this bank.
    end
  end

endmodule

//--- logic/mem_mux_dynamic.sv
//####################################################################
// Round-robin mux of NB_IN_CHAN channels onto NB_OUT_CHAN ports.
// Channel j only uses port j % NB_OUT_CHAN. No reorder buffer.
// Responses are not back-pressured and arrive one cycle after grant.
//####################################################################

`timescale 1ns/1ns

`include "mem_mux_config.svh"

module mem_mux_dynamic #(
  parameter int unsigned NB_IN_CHAN  = `MEM_NB_IN_CHAN,
  parameter int unsigned NB_OUT_CHAN = `MEM_NB_OUT_CHAN
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,

  // channel side.
  input  logic                  [NB_IN_CHAN-1:0]  in_req,
  input  mem_mux_pkg::mem_req_t [NB_IN_CHAN-1:0]  in_req_data,
  output logic                  [NB_IN_CHAN-1:0]  in_gnt,
  output logic                  [NB_IN_CHAN-1:0]  in_r_valid,
  output mem_mux_pkg::mem_rsp_t [NB_IN_CHAN-1:0]  in_rsp,

  // bank side.
  output logic                  [NB_OUT_CHAN-1:0] out_req,
  output mem_mux_pkg::mem_req_t [NB_OUT_CHAN-1:0] out_req_data,
  input  logic                  [NB_OUT_CHAN-1:0] out_gnt,
  input  logic                  [NB_OUT_CHAN-1:0] out_r_valid,
  input  mem_mux_pkg::mem_rsp_t [NB_OUT_CHAN-1:0] out_rsp
);

  // channels competing for one port, and the index width inside a group.
  localparam int unsigned NG = NB_IN_CHAN / NB_OUT_CHAN;
  localparam int unsigned CW = (NG > 1) ? $clog2(NG) : 1;

  logic [CW-1:0]                  rr_counter;
  logic                           rr_en;
  logic [NB_OUT_CHAN-1:0][CW-1:0] winner_d;
  logic [NB_OUT_CHAN-1:0][CW-1:0] winner_q;
  logic [NB_OUT_CHAN-1:0]         out_req_q;

  //####################################################################
  // round-robin counter
  //####################################################################

  // Move on only when a port granted and somebody was left waiting.
  assign rr_en = (|(out_req & out_gnt)) & (|(in_req & ~in_gnt));

  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_counter_reg
    if (!rst_ni) begin
      rr_counter <= '0;
    end else if (clear_i) begin
      rr_counter <= '0;
    end else if (rr_en) begin
      if (rr_counter == CW'(NG - 1)) begin
        rr_counter <= '0;  // wrap inside the group.
      end else begin
        rr_counter <= rr_counter + 1'b1;
      end
    end
  end

  //####################################################################
  // arbitration and request path
  //####################################################################

  // For port i the group members are k*NB_OUT_CHAN + i. The scan starts
  // at (counter + i) % NG so that neighbouring ports start at different
  // members, and the first requester found wins.
  always_comb begin : arbiter
    int unsigned start;
    int unsigned cand;
    logic        found;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      start       = (int'(rr_counter) + i) % NG;
      found       = 1'b0;
      winner_d[i] = CW'(start);
      for (int unsigned k = 0; k < NG; k++) begin
        cand = (start + k) % NG;
        if (!found && in_req[cand*NB_OUT_CHAN + i]) begin
          found       = 1'b1;
          winner_d[i] = CW'(cand);
        end
      end
      out_req[i]      = found;
      out_req_data[i] = in_req_data[winner_d[i]*NB_OUT_CHAN + i];
    end
  end

  //####################################################################
  // grant and response path
  //####################################################################

  // The response of a port belongs to whoever won it one cycle earlier.
  always_ff @(posedge clk_i or negedge rst_ni) begin : resp_regs
    if (!rst_ni) begin
      winner_q  <= '0;
      out_req_q <= '0;
    end else if (clear_i) begin
      winner_q  <= '0;
      out_req_q <= '0;
    end else begin
      winner_q  <= winner_d;
      out_req_q <= out_req;
    end
  end

  always_comb begin : route_back
    int unsigned ch_d;
    int unsigned ch_q;
    in_gnt     = '0;
    in_r_valid = '0;
    in_rsp     = '0;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      ch_d = winner_d[i]*NB_OUT_CHAN + i;
      ch_q = winner_q[i]*NB_OUT_CHAN + i;
      in_gnt[ch_d]     = out_gnt[i];                   // only the current winner.
      in_r_valid[ch_q] = out_r_valid[i] & out_req_q[i];
      in_rsp[ch_q]     = out_rsp[i];                   // every field from the old winner.
    end
  end

endmodule

//--- logic/mem_mux_pkg.sv
//####################################################################
// Request and response payloads shared by channels, mux and banks.
// Field widths come from the config header.
//####################################################################

`include "mem_mux_config.svh"

package mem_mux_pkg;

  // one request beat as presented with req.
  typedef struct packed {
    logic [`MEM_AW-1:0]   addr;  // word address inside the bank.
    logic                 wen;   // high for a read, low for a write.
    logic [`MEM_DW/8-1:0] be;    // byte enables, used by writes only.
    logic [`MEM_DW-1:0]   data;  // write data.
    logic [`MEM_IW-1:0]   id;
  } mem_req_t;

  // Response returned with r_valid one cycle after the grant.
  typedef struct packed {
    logic [`MEM_DW-1:0] data;  // read word, zero for writes.
    logic [`MEM_IW-1:0] id;    // copied from the request.
    logic               opc;   // zero on a normal completion.
  } mem_rsp_t;

  // The response data must be able to carry any word a write
  // can put into a bank.
  localparam int unsigned MEM_REQ_BITS = $bits(mem_req_t);
  localparam int unsigned MEM_RSP_BITS = $bits(mem_rsp_t);

endpackage

//--- logic/mem_mux_subsys.sv
//####################################################################
// Channel mux feeding one single-port bank per output port.
// Channel j always lands in bank j % NB_OUT_CHAN.
//####################################################################

`timescale 1ns/1ns

`include "mem_mux_config.svh"

module mem_mux_subsys #(
  parameter int unsigned NB_IN_CHAN  = `MEM_NB_IN_CHAN,
  parameter int unsigned NB_OUT_CHAN = `MEM_NB_OUT_CHAN
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,

  input  logic                  [NB_IN_CHAN-1:0]  in_req,
  input  mem_mux_pkg::mem_req_t [NB_IN_CHAN-1:0]  in_req_data,
  output logic                  [NB_IN_CHAN-1:0]  in_gnt,
  output logic                  [NB_IN_CHAN-1:0]  in_r_valid,
  output mem_mux_pkg::mem_rsp_t [NB_IN_CHAN-1:0]  in_rsp,

  input  logic                  [NB_OUT_CHAN-1:0] bank_stall  // one stall per bank.
);

  // bank port wires between the mux and the banks.
  logic                  [NB_OUT_CHAN-1:0] out_req;
  mem_mux_pkg::mem_req_t [NB_OUT_CHAN-1:0] out_req_data;
  logic                  [NB_OUT_CHAN-1:0] out_gnt;
  logic                  [NB_OUT_CHAN-1:0] out_r_valid;
  mem_mux_pkg::mem_rsp_t [NB_OUT_CHAN-1:0] out_rsp;

  mem_mux_dynamic #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN)
  ) i_mux (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .in_req       (in_req),
    .in_req_data  (in_req_data),
    .in_gnt       (in_gnt),
    .in_r_valid   (in_r_valid),
    .in_rsp       (in_rsp),
    .out_req      (out_req),
    .out_req_data (out_req_data),
    .out_gnt      (out_gnt),
    .out_r_valid  (out_r_valid),
    .out_rsp      (out_rsp)
  );

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_bank
    mem_bank i_bank (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .stall    (bank_stall[i]),
      .req      (out_req[i]),
      .req_data (out_req_data[i]),
      .gnt      (out_gnt[i]),
      .r_valid  (out_r_valid[i]),
      .rsp      (out_rsp[i])
    );
  end

endmodule

//--- test/mem_mux_sva.sv
//####################################################################
// Handshake and routing properties for the channel multiplexer.
// A grant taken while clear_i is high loses its response by design.
//####################################################################

`timescale 1ns/1ns

`include "mem_mux_config.svh"

module mem_mux_sva #(
  parameter int unsigned NB_IN_CHAN  = `MEM_NB_IN_CHAN,
  parameter int unsigned NB_OUT_CHAN = `MEM_NB_OUT_CHAN
) (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  clear_i,
  input logic [NB_IN_CHAN-1:0] in_req,
  input logic [NB_IN_CHAN-1:0] in_gnt,
  input logic [NB_IN_CHAN-1:0] in_r_valid
);

  localparam int unsigned NG = NB_IN_CHAN / NB_OUT_CHAN;

  logic [NB_OUT_CHAN-1:0][NG-1:0] grp_gnt;  // grants seen by each port.
  int unsigned                    fail_cnt = 0;  // number of failed assertions so far.

  always_comb begin : group_grants
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      for (int unsigned k = 0; k < NG; k++) begin
        grp_gnt[i][k] = in_gnt[k*NB_OUT_CHAN + i];
      end
    end
  end

  for (genvar c = 0; c < NB_IN_CHAN; c++) begin : gen_chan
    gnt_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_gnt[c] |-> in_req[c])
    else begin
      $error("channel %0d granted without a request", c);
      fail_cnt++;
    end
    rsp_after_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (in_gnt[c] && !clear_i) |=> in_r_valid[c])
    else begin
      $error("channel %0d lost a response", c);
      fail_cnt++;
    end
    rsp_needs_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_r_valid[c] |-> $past(in_gnt[c]))
    else begin
      $error("channel %0d got a stray r_valid", c);
      fail_cnt++;
    end
  end

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : gen_port
    one_gnt_per_port : assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(grp_gnt[i]))
    else begin
      $error("port %0d granted several channels", i);
      fail_cnt++;
    end
  end

endmodule

bind mem_mux_dynamic mem_mux_sva #(
  .NB_IN_CHAN  (NB_IN_CHAN),
  .NB_OUT_CHAN (NB_OUT_CHAN)
) i_sva (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .clear_i    (clear_i),
  .in_req     (in_req),
  .in_gnt     (in_gnt),
  .in_r_valid (in_r_valid)
);

//--- test/mem_mux_tb.sv
//####################################################################
// Random channel traffic against a reference model of the banks.
// Every bank word is written once before any read so no X is read.
//####################################################################

`timescale 1ns/1ns

`include "mem_mux_config.svh"

module mem_mux_tb;

  localparam int unsigned NIN      = `MEM_NB_IN_CHAN;
  localparam int unsigned NOUT     = `MEM_NB_OUT_CHAN;
  localparam int unsigned NG       = NIN / NOUT;
  localparam int unsigned DEPTH    = 2 ** `MEM_AW;
  localparam int unsigned NUM_TXN  = 600;
  localparam int unsigned NUM_FILL = NOUT * DEPTH;
  localparam longint unsigned WATCHDOG_NS = (NUM_FILL + NUM_TXN) * 40 * 20 + 2000;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            clear_i;
  logic                  [NIN-1:0]  in_req;
  mem_mux_pkg::mem_req_t [NIN-1:0]  in_req_data;
  logic                  [NIN-1:0]  in_gnt;
  logic                  [NIN-1:0]  in_r_valid;
  mem_mux_pkg::mem_rsp_t [NIN-1:0]  in_rsp;
  logic                  [NOUT-1:0] bank_stall;

  logic [`MEM_DW-1:0]    model_mem [NOUT][DEPTH];
  mem_mux_pkg::mem_rsp_t exp_rsp [NIN];   // one slot per channel.
  logic [NIN-1:0]        rsp_due;         // r_valid expected at the next sample.
  logic [NIN-1:0]        granted;
  logic [`MEM_IW-1:0]    id_cnt [NIN];
  int unsigned           others_won [NIN];
  int unsigned           fill_addr [NOUT];
  int unsigned           issued;
  logic                  fill_phase;
  logic                  do_clear;

  mem_mux_subsys i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_req      (in_req),
    .in_req_data (in_req_data),
    .in_gnt      (in_gnt),
    .in_r_valid  (in_r_valid),
    .in_rsp      (in_rsp),
    .bank_stall  (bank_stall)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic abort_run(string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_rsp(string name, mem_mux_pkg::mem_rsp_t exp, mem_mux_pkg::mem_rsp_t act);
    if (act !== exp) abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) abort_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic new_request(int unsigned c);
    mem_mux_pkg::mem_req_t r;
    r.id   = id_cnt[c];
    r.data = $urandom;
    if (fill_phase) begin
      r.addr = fill_addr[c];  // full-word writes sweep the whole bank.
      r.wen  = 1'b0;
      r.be   = '1;
      fill_addr[c]++;
    end else begin
      r.addr = $urandom % DEPTH;
      r.wen  = $urandom % 2;
      r.be   = $urandom;
      issued++;
    end
    id_cnt[c]      = id_cnt[c] + 1'b1;
    in_req_data[c] = r;
    in_req[c]      = 1'b1;
  endtask

  task automatic drive_inputs();
    clear_i  = do_clear;
    do_clear = 1'b0;
    for (int unsigned b = 0; b < NOUT; b++) bank_stall[b] = ($urandom % 4 == 0);
    for (int unsigned c = 0; c < NIN; c++) begin
      if (in_req[c] && granted[c]) in_req[c] = 1'b0;  // transfer done at this edge.
      if (!in_req[c]) begin
        if (fill_phase) begin
          if (c < NOUT && fill_addr[c] < DEPTH) new_request(c);
        end else if (issued < NUM_TXN && $urandom % 4 != 0) begin
          new_request(c);
        end
      end
    end
  endtask

  // Responses of the previous cycle are checked before new grants fill the slots.
  task automatic observe();
    mem_mux_pkg::mem_req_t r;
    mem_mux_pkg::mem_rsp_t e;
    int unsigned           b;
    int unsigned           n;
    logic                  any_req;
    if (i_dut.i_mux.i_sva.fail_cnt != 0) abort_run("an assertion in the mux checker failed");
    for (int unsigned c = 0; c < NIN; c++) begin
      check_flag($sformatf("r_valid ch%0d", c), rsp_due[c], in_r_valid[c]);
      if (rsp_due[c]) check_rsp($sformatf("response ch%0d", c), exp_rsp[c], in_rsp[c]);
    end
    rsp_due = '0;
    for (int unsigned c = 0; c < NIN; c++) begin
      b = c % NOUT;
      if (in_gnt[c]) begin
        check_flag($sformatf("grant ch%0d on free bank", c), 1'b1, in_req[c] & ~bank_stall[b]);
        r      = in_req_data[c];
        e.id   = r.id;
        e.opc  = 1'b0;
        e.data = r.wen ? model_mem[b][r.addr] : '0;
        if (!r.wen) begin
          for (int unsigned k = 0; k < `MEM_DW/8; k++) begin
            if (r.be[k]) model_mem[b][r.addr][8*k +: 8] = r.data[8*k +: 8];
          end
        end
        exp_rsp[c] = e;
        rsp_due[c] = ~clear_i;  // a grant that meets the clear gets no response.
      end
      granted[c] = in_gnt[c];
    end
    for (int unsigned i = 0; i < NOUT; i++) begin
      n       = 0;
      any_req = 1'b0;
      for (int unsigned k = 0; k < NG; k++) begin
        n += in_gnt[k*NOUT + i];
        any_req |= in_req[k*NOUT + i];
      end
      check_flag($sformatf("single grant on port %0d", i), any_req & ~bank_stall[i], n == 1);
    end
    // a clear restarts the rotation, so the count starts over.
    for (int unsigned c = 0; c < NIN; c++) begin
      if (in_req[c] && !in_gnt[c] && !bank_stall[c % NOUT] && !clear_i) begin
        for (int unsigned k = 0; k < NG; k++) begin
          if (k*NOUT + c % NOUT != c && in_gnt[k*NOUT + c % NOUT]) others_won[c]++;
        end
        if (others_won[c] >= NG) abort_run($sformatf("channel %0d was passed over twice", c));
      end else begin
        others_won[c] = 0;
      end
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #2;
    drive_inputs();
    @(negedge clk_i);
    observe();
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run("timeout: the traffic did not finish in the expected time");
  end

  initial begin : main
    void'($urandom(32'h9f4c_3ea8));
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    in_req      = '0;
    in_req_data = '0;
    bank_stall  = '0;
    rsp_due     = '0;
    granted     = '0;
    issued      = 0;
    fill_phase  = 1'b1;
    do_clear    = 1'b0;
    for (int unsigned c = 0; c < NIN; c++) begin
      id_cnt[c]     = '0;
      others_won[c] = 0;
    end
    for (int unsigned b = 0; b < NOUT; b++) fill_addr[b] = 0;
    repeat (5) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    // ################ bank fill ################
    do begin
      step();
    end while (fill_addr[0] < DEPTH || fill_addr[NOUT-1] < DEPTH || |in_req || |rsp_due);
    fill_phase = 1'b0;
    // ################ random traffic, clear pulse halfway ################
    while (issued < NUM_TXN / 2) step();
    do_clear = 1'b1;  // the clear meets live traffic.
    step();
    while (issued < NUM_TXN || |in_req || |rsp_due) step();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
